// ==== Makefile ====
TOP = tb_axi_aw_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "tests failed" sim.log; then exit 1; fi
	@grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_axi_aw_top.sv ====
/*
 * testbench for the AXI AW issuer
 * programs bursts over APB, checks the AW port and the checker registers
 */

`timescale 1ns/1ps

`include "axi_aw_macros.svh"

module tb_axi_aw_top;

  localparam int READY_HIGH = 0;
  localparam int READY_LOW  = 1;
  localparam int READY_RAND = 2;

  logic                   aclk;
  logic                   rst_n;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [7:0]             paddr;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;
  logic [`AW_ID_W-1:0]    awid;
  logic [`AW_ADDR_W-1:0]  awaddr;
  logic [7:0]             awlen;
  logic [2:0]             awsize;
  logic [1:0]             awburst;
  logic                   awlock;
  logic [2:0]             awprot;
  logic                   awvalid;
  logic                   awready;

  // expected commands as {address, attribute word}
  logic [63:0]  exp_q[$];
  logic [31:0]  lcg_state;
  logic [52:0]  last_payload;
  bit           last_stall;
  bit           timed_out;
  int           ready_mode;
  int           hs_count;
  int           errors;
  int           checks;
  int           tests;
  int           test_start;

  axi_aw_top uut (
    .aclk(aclk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .awid(awid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize), .awburst(awburst),
    .awlock(awlock), .awprot(awprot), .awvalid(awvalid), .awready(awready)
  );

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // slave side of the AW port
  always @(posedge aclk) begin
    if (ready_mode == READY_HIGH) begin
      awready <= 1'b1;
    end else if (ready_mode == READY_LOW) begin
      awready <= 1'b0;
    end else begin
      lcg_state = lcg_next(lcg_state);
      awready <= lcg_state[16];
    end
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task end_test(input string name);
    tests++;
    if (errors == test_start) begin
      $display("test %s: pass", name);
    end else begin
      $display("test %s: %0d errors", name, errors - test_start);
    end
    test_start = errors;
  endtask

  // setup cycle then access cycle with the response taken mid access
  task apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    @(posedge aclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge aclk);
    penable <= 1'b1;
    @(negedge aclk);
    err = pslverr;
    check("pready", 32'(pready), 32'd1);
    @(posedge aclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge aclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge aclk);
    penable <= 1'b1;
    @(negedge aclk);
    data = prdata;
    check("pready", 32'(pready), 32'd1);
    @(posedge aclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  function automatic axi_aw_pkg::aw_attr_t make_attr(input logic [3:0] id,
      input logic [7:0] len, input logic [2:0] size, input logic [1:0] burst,
      input logic lock, input logic [2:0] prot);
    axi_aw_pkg::aw_attr_t a;
    a.raw            = '0;
    a.fields.awid    = id;
    a.fields.awlen   = len;
    a.fields.awsize  = size;
    a.fields.awburst = burst;
    a.fields.awlock  = lock;
    a.fields.awprot  = prot;
    return a;
  endfunction

  // expected flags straight from the AXI burst rules
  function automatic axi_aw_pkg::aw_viol_t ref_viol(input logic [31:0] addr,
      input logic [7:0] len, input logic [2:0] size, input logic [1:0] burst);
    axi_aw_pkg::aw_viol_t v;
    int beat;
    int bytes;
    beat  = 1 << size;
    bytes = (int'(len) + 1) * beat;
    v.burst_reserved = (burst == 2'd3);
    v.wrap_len       = (burst == 2'd2) && !(int'(len) inside {1, 3, 7, 15});
    v.wrap_align     = (burst == 2'd2) && ((int'(addr[6:0]) % beat) != 0);
    v.cross_4k       = (burst == 2'd1) && (int'(addr[11:0]) + bytes > 4096);
    return v;
  endfunction

  task send_cmd(input logic [31:0] addr, input axi_aw_pkg::aw_attr_t attr, output logic err);
    logic dummy;
    apb_write(`REG_ADDR, addr, dummy);
    apb_write(`REG_ATTR, attr.raw, dummy);
    apb_write(`REG_CMD, 32'd0, err);
    if (!err) begin
      exp_q.push_back({addr, attr.raw});
    end
  endtask

  task wait_handshakes(input int target);
    int cycles;
    cycles = 0;
    while (hs_count < target && cycles < 400 && !timed_out) begin
      @(posedge aclk);
      cycles++;
    end
    if (hs_count < target) begin
      timed_out = 1'b1;
      errors++;
      $display("timeout: saw %0d handshakes, waited for %0d", hs_count, target);
    end
  endtask

  task automatic run_viol_case(input logic [31:0] addr, input axi_aw_pkg::aw_attr_t attr);
    axi_aw_pkg::aw_viol_t ev;
    logic [31:0] rd;
    logic err;
    int target;
    target = hs_count + 1;
    ev = ref_viol(addr, attr.fields.awlen, attr.fields.awsize, attr.fields.awburst);
    send_cmd(addr, attr, err);
    check("pslverr", 32'(err), 32'd0);
    wait_handshakes(target);
    apb_read(`REG_VIOL, rd);
    check("viol", rd, 32'(ev));
    apb_write(`REG_VIOL, 32'hF, err);
    apb_read(`REG_VIOL, rd);
    check("viol after clear", rd, 32'd0);
  endtask

  // ----------------------------------------------------------------------
  // AW monitor sampled mid cycle so the next edge is predictable
  // ----------------------------------------------------------------------
  always @(negedge aclk) begin
    logic [63:0] exp_entry;
    axi_aw_pkg::aw_attr_t ea;
    logic [52:0] payload;
    payload = {awid, awaddr, awlen, awsize, awburst, awlock, awprot};
    if (rst_n) begin
      if (last_stall) begin
        checks++;
        if (awvalid !== 1'b1 || payload !== last_payload) begin
          errors++;
          $display("error at %0t: awvalid/payload got %b/%h expected 1/%h",
                   $time, awvalid, payload, last_payload);
        end
      end
      if (awvalid === 1'b1 && awready === 1'b1) begin
        hs_count++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("handshake at %0t with no command queued", $time);
        end else begin
          exp_entry = exp_q.pop_front();
          ea.raw    = exp_entry[31:0];
          check("awaddr", awaddr, exp_entry[63:32]);
          check("awid", 32'(awid), 32'(ea.fields.awid));
          check("awlen", 32'(awlen), 32'(ea.fields.awlen));
          check("awsize", 32'(awsize), 32'(ea.fields.awsize));
          check("awburst", 32'(awburst), 32'(ea.fields.awburst));
          check("awlock", 32'(awlock), 32'(ea.fields.awlock));
          check("awprot", 32'(awprot), 32'(ea.fields.awprot));
        end
      end
    end
    last_stall   = rst_n && (awvalid === 1'b1) && (awready === 1'b0);
    last_payload = payload;
  end

  initial begin
    axi_aw_pkg::aw_attr_t attr;
    logic [31:0] rd;
    logic err;
    int target;
    int accepted;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = 8'd0;
    pwdata     = 32'd0;
    awready    = 1'b0;
    rst_n      = 1'b0;
    ready_mode = READY_LOW;
    lcg_state  = 32'd17;
    hs_count   = 0;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    test_start = 0;
    timed_out  = 1'b0;
    repeat (2) @(posedge aclk);
    rst_n <= 1'b1;

    @(negedge aclk);
    check("awvalid", 32'(awvalid), 32'd0);
    apb_read(`REG_CMD, rd);
    check("cmd status", rd, 32'd0);
    apb_read(`REG_VIOL, rd);
    check("viol", rd, 32'd0);
    apb_read(`REG_COUNT, rd);
    check("count", rd, 32'd0);
    end_test("reset");

    ready_mode <= READY_HIGH;
    attr = make_attr(4'd5, 8'd3, 3'd2, 2'd1, 1'b0, 3'd2);
    send_cmd(32'h1000_0100, attr, err);
    check("pslverr", 32'(err), 32'd0);
    wait_handshakes(1);
    apb_read(`REG_VIOL, rd);
    check("viol", rd, 32'd0);
    apb_read(`REG_COUNT, rd);
    check("count", rd, 32'd1);
    end_test("legal_burst");

    ready_mode <= READY_RAND;
    for (int i = 0; i < 4; i++) begin
      attr = make_attr(4'(i), 8'(i * 2), 3'd2, 2'd1, 1'b1, 3'(i));
      send_cmd(32'h4000_0000 + 32'(i) * 32'h100, attr, err);
      check("pslverr", 32'(err), 32'd0);
    end
    wait_handshakes(5);
    end_test("back_pressure");

    ready_mode <= READY_HIGH;
    run_viol_case(32'h0000_2000, make_attr(4'd1, 8'd0, 3'd2, 2'd3, 1'b0, 3'd0));
    run_viol_case(32'h0000_0040, make_attr(4'd2, 8'd2, 3'd2, 2'd2, 1'b0, 3'd0));
    run_viol_case(32'h0000_0042, make_attr(4'd3, 8'd3, 3'd2, 2'd2, 1'b0, 3'd0));
    run_viol_case(32'h0000_0FC0, make_attr(4'd4, 8'd15, 3'd3, 2'd1, 1'b0, 3'd0));
    end_test("violations");

    ready_mode <= READY_LOW;
    target   = hs_count;
    accepted = 0;
    err      = 1'b0;
    while (!err && accepted < 8) begin
      attr = make_attr(4'd6, 8'd1, 3'd2, 2'd1, 1'b0, 3'd1);
      send_cmd(32'h5000_0000 + 32'(accepted) * 32'h40, attr, err);
      if (!err) begin
        accepted++;
      end
    end
    // one burst waits on the AW port and the rest fill the queue
    check("accepted commands", 32'(accepted), 32'(`CMD_DEPTH + 1));
    check("pslverr", 32'(err), 32'd1);
    apb_read(`REG_CMD, rd);
    check("cmd status", rd, {28'd0, 1'b1, 3'(`CMD_DEPTH)});
    ready_mode <= READY_HIGH;
    wait_handshakes(target + accepted);
    repeat (20) @(posedge aclk);
    check("handshakes after release", 32'(hs_count - target), 32'(accepted));
    end_test("overflow");

    apb_read(`REG_COUNT, rd);
    check("count", rd, 32'(hs_count));
    check("commands left", 32'(exp_q.size()), 32'd0);
    end_test("count");

    if (timed_out) begin
      $display("run stopped early waiting for the DUT");
    end
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== include/axi_aw_macros.svh ====
/*
 * AXI AW issuer shared parameters
 * bus widths, command queue depth and APB register map
 */

`ifndef AXI_AW_MACROS_SVH
`define AXI_AW_MACROS_SVH

// ----------------------------------------------------------------------
// AW channel widths
// ----------------------------------------------------------------------
`define AW_ADDR_W 32
`define AW_ID_W   4

// command queue entries, keep a power of two
`define CMD_DEPTH 4

// ----------------------------------------------------------------------
// APB register byte offsets
// ----------------------------------------------------------------------
`define REG_ADDR  8'h00
`define REG_ATTR  8'h04
`define REG_CMD   8'h08
`define REG_VIOL  8'h0C
`define REG_COUNT 8'h10

`endif

// ==== src/apb_aw_regs.sv ====
/*
 * APB register file for the AW issuer
 * holds start address and attribute, turns CMD writes into queue pushes
 */

`timescale 1ns/1ps

`include "axi_aw_macros.svh"

module apb_aw_regs (
  input  logic                     aclk,
  input  logic                     rst_n,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [7:0]               paddr,
  input  logic [31:0]              pwdata,
  output logic [31:0]              prdata,
  output logic                     pready,
  output logic                     pslverr,
  output logic                     push,
  output logic [`AW_ADDR_W-1:0]    push_addr,
  output axi_aw_pkg::aw_attr_t     push_attr,
  input  logic                     full,
  input  logic [2:0]               level,
  input  logic                     busy,
  input  axi_aw_pkg::aw_viol_t     viol,
  output logic [3:0]               viol_clear,
  input  logic [15:0]              accept_count
);

  logic                   access;
  logic                   wr_access;
  logic                   cmd_write;
  logic [`AW_ADDR_W-1:0]  addr_q;
  axi_aw_pkg::aw_attr_t   attr_q;

  // ----------------------------------------------------------------------
  // access decode
  // ----------------------------------------------------------------------
  // no wait states
  assign pready    = 1'b1;
  assign access    = psel && penable;
  assign wr_access = access && pwrite;
  assign cmd_write = wr_access && (paddr == `REG_CMD);

  // command goes in only if there is room
  assign push      = cmd_write && !full;
  assign pslverr   = cmd_write && full;
  assign push_addr = addr_q;
  assign push_attr = attr_q;

  // write one to clear
  assign viol_clear = (wr_access && (paddr == `REG_VIOL)) ? pwdata[3:0] : 4'd0;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      addr_q <= '0;
      attr_q <= '0;
    end else if (wr_access) begin
      if (paddr == `REG_ADDR) begin
        addr_q <= pwdata[`AW_ADDR_W-1:0];
      end
      if (paddr == `REG_ATTR) begin
        attr_q.raw <= pwdata;
      end
    end
  end

  // ----------------------------------------------------------------------
  // read mux
  // ----------------------------------------------------------------------
  always_comb begin
    case (paddr)
      `REG_ADDR:  prdata = addr_q;
      `REG_ATTR:  prdata = attr_q.raw;
      `REG_CMD:   prdata = {28'd0, busy, level};
      `REG_VIOL:  prdata = {28'd0, viol};
      `REG_COUNT: prdata = {16'd0, accept_count};
      default:    prdata = 32'd0;
    endcase
  end

  // error only in an access phase that followed a proper setup phase
  a_pslverr_access: assert property (
    @(posedge aclk) disable iff (!rst_n)
    pslverr |-> (psel && penable && $past(psel && !penable))
  );

endmodule

// ==== src/aw_channel_master.sv ====
/*
 * AW channel master
 * takes queued commands and holds them on the AW port until accepted
 */

`timescale 1ns/1ps

`include "axi_aw_macros.svh"

module aw_channel_master (
  input  logic                     aclk,
  input  logic                     rst_n,
  input  logic                     empty,
  input  logic [`AW_ADDR_W-1:0]    head_addr,
  input  axi_aw_pkg::aw_attr_t     head_attr,
  output logic                     pop,
  output logic                     busy,
  output logic [`AW_ID_W-1:0]      awid,
  output logic [`AW_ADDR_W-1:0]    awaddr,
  output logic [7:0]               awlen,
  output logic [2:0]               awsize,
  output logic [1:0]               awburst,
  output logic                     awlock,
  output logic [2:0]               awprot,
  output logic                     awvalid,
  input  logic                     awready
);

  localparam logic S_IDLE  = 1'b0;
  localparam logic S_ISSUE = 1'b1;

  logic                   state_q;
  logic [`AW_ADDR_W-1:0]  cmd_addr;
  axi_aw_pkg::aw_attr_t   cmd_attr;

  // take the head entry only between bursts
  assign pop = (state_q == S_IDLE) && !empty;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (!empty) begin
            state_q <= S_ISSUE;
          end
        end
        default: begin
          // handshake ends the burst
          if (awready) begin
            state_q <= S_IDLE;
          end
        end
      endcase
    end
  end

  // payload latched on pop and held while issuing
  always_ff @(posedge aclk) begin
    if (pop) begin
      cmd_addr <= head_addr;
      cmd_attr <= head_attr;
    end
  end

  // ----------------------------------------------------------------------
  // AW port
  // ----------------------------------------------------------------------
  assign awvalid = (state_q == S_ISSUE);
  assign busy    = awvalid;
  assign awaddr  = cmd_addr;
  assign awid    = cmd_attr.fields.awid;
  assign awlen   = cmd_attr.fields.awlen;
  assign awsize  = cmd_attr.fields.awsize;
  assign awburst = cmd_attr.fields.awburst;
  assign awlock  = cmd_attr.fields.awlock;
  assign awprot  = cmd_attr.fields.awprot;

  a_valid_held: assert property (
    @(posedge aclk) disable iff (!rst_n)
    (awvalid && !awready) |=> awvalid
  );

  a_payload_stable: assert property (
    @(posedge aclk) disable iff (!rst_n)
    (awvalid && !awready) |=>
      $stable({awid, awaddr, awlen, awsize, awburst, awlock, awprot})
  );

endmodule

// ==== src/aw_cmd_fifo.sv ====
/*
 * AW command queue
 * circular buffer of address and attribute pairs with fill level
 */

`timescale 1ns/1ps

`include "axi_aw_macros.svh"

module aw_cmd_fifo (
  input  logic                     aclk,
  input  logic                     rst_n,
  input  logic                     push,
  input  logic                     pop,
  input  logic [`AW_ADDR_W-1:0]    push_addr,
  input  axi_aw_pkg::aw_attr_t     push_attr,
  output logic [`AW_ADDR_W-1:0]    head_addr,
  output axi_aw_pkg::aw_attr_t     head_attr,
  output logic                     empty,
  output logic                     full,
  output logic [2:0]               level
);

  localparam int PTR_W = $clog2(`CMD_DEPTH);

  logic [`AW_ADDR_W-1:0]  addr_mem [`CMD_DEPTH];
  axi_aw_pkg::aw_attr_t   attr_mem [`CMD_DEPTH];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [2:0]             level_q;

  // storage
  always_ff @(posedge aclk) begin
    if (push) begin
      addr_mem[wr_ptr] <= push_addr;
      attr_mem[wr_ptr] <= push_attr;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      level_q <= 3'd0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   level_q <= level_q + 3'd1;
        2'b01:   level_q <= level_q - 3'd1;
        default: level_q <= level_q;
      endcase
    end
  end

  assign head_addr = addr_mem[rd_ptr];
  assign head_attr = attr_mem[rd_ptr];
  assign level     = level_q;
  assign empty     = (level_q == 3'd0);
  assign full      = (level_q == 3'(`CMD_DEPTH));

  // the register block and the master must respect the flags
  a_no_push_full: assert property (
    @(posedge aclk) disable iff (!rst_n) push |-> !full
  );

  a_no_pop_empty: assert property (
    @(posedge aclk) disable iff (!rst_n) pop |-> !empty
  );

endmodule

// ==== src/aw_protocol_checker.sv ====
/*
 * AW protocol checker
 * classifies every accepted burst into sticky violation flags
 * and counts handshakes
 */

`timescale 1ns/1ps

`include "axi_aw_macros.svh"

module aw_protocol_checker (
  input  logic                     aclk,
  input  logic                     rst_n,
  input  logic [`AW_ADDR_W-1:0]    awaddr,
  input  logic [7:0]               awlen,
  input  logic [2:0]               awsize,
  input  logic [1:0]               awburst,
  input  logic                     awvalid,
  input  logic                     awready,
  input  logic [3:0]               viol_clear,
  output axi_aw_pkg::aw_viol_t     viol,
  output logic [15:0]              accept_count
);

  localparam logic [1:0] BURST_INCR = 2'b01;
  localparam logic [1:0] BURST_WRAP = 2'b10;
  localparam logic [1:0] BURST_RSVD = 2'b11;

  logic                  handshake;
  logic [15:0]           burst_bytes;
  logic [16:0]           burst_end;
  logic [7:0]            size_mask;
  logic                  len_ok;
  axi_aw_pkg::aw_viol_t  hit;

  assign handshake = awvalid && awready;

  // ----------------------------------------------------------------------
  // burst classification
  // ----------------------------------------------------------------------
  always_comb begin
    // total bytes of the burst, at most 256 beats of 128 bytes
    burst_bytes = ({8'd0, awlen} + 16'd1) << awsize;
    // end offset within the 4 KB page
    burst_end   = {5'd0, awaddr[11:0]} + {1'b0, burst_bytes};
    size_mask   = (8'd1 << awsize) - 8'd1;
    // wrap bursts take 2, 4, 8 or 16 beats
    len_ok      = (awlen == 8'd1) || (awlen == 8'd3) ||
                  (awlen == 8'd7) || (awlen == 8'd15);

    hit.burst_reserved = (awburst == BURST_RSVD);
    hit.wrap_len       = (awburst == BURST_WRAP) && !len_ok;
    hit.wrap_align     = (awburst == BURST_WRAP) && ((awaddr[7:0] & size_mask) != 8'd0);
    hit.cross_4k       = (awburst == BURST_INCR) && (burst_end > 17'd4096);
  end

  // ----------------------------------------------------------------------
  // sticky flags and counter
  // ----------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      viol         <= '0;
      accept_count <= 16'd0;
    end else begin
      // a new hit wins over a clear in the same cycle
      viol <= (viol & ~viol_clear) | (hit & {4{handshake}});
      if (handshake) begin
        accept_count <= accept_count + 16'd1;
      end
    end
  end

  // the master must never present unknown payload
  a_no_x_payload: assert property (
    @(posedge aclk) disable iff (!rst_n)
    awvalid |-> !$isunknown({awaddr, awlen, awsize})
  );

endmodule

// ==== src/axi_aw_pkg.sv ====
/*
 * AXI AW issuer types
 * burst attribute word and protocol violation flags
 */

`include "axi_aw_macros.svh"

package axi_aw_pkg;

  // attribute word as written over APB, or split into AW fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [10:0]          rsvd;
      logic [2:0]           awprot;
      logic                 awlock;
      logic [1:0]           awburst;
      logic [2:0]           awsize;
      logic [7:0]           awlen;
      logic [`AW_ID_W-1:0]  awid;
    } fields;
  } aw_attr_t;

  // sticky checker flags, burst_reserved sits in bit 0
  typedef struct packed {
    logic cross_4k;
    logic wrap_align;
    logic wrap_len;
    logic burst_reserved;
  } aw_viol_t;

endpackage

// ==== src/axi_aw_top.sv ====
/*
 * AXI AW issuer top level
 * APB registers, command queue, AW master and protocol checker
 */

`timescale 1ns/1ps

`include "axi_aw_macros.svh"

module axi_aw_top (
  input  logic                     aclk,
  input  logic                     rst_n,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [7:0]               paddr,
  input  logic [31:0]              pwdata,
  output logic [31:0]              prdata,
  output logic                     pready,
  output logic                     pslverr,
  output logic [`AW_ID_W-1:0]      awid,
  output logic [`AW_ADDR_W-1:0]    awaddr,
  output logic [7:0]               awlen,
  output logic [2:0]               awsize,
  output logic [1:0]               awburst,
  output logic                     awlock,
  output logic [2:0]               awprot,
  output logic                     awvalid,
  input  logic                     awready
);

  logic                   push;
  logic                   pop;
  logic [`AW_ADDR_W-1:0]  push_addr;
  logic [`AW_ADDR_W-1:0]  head_addr;
  axi_aw_pkg::aw_attr_t   push_attr;
  axi_aw_pkg::aw_attr_t   head_attr;
  logic                   empty;
  logic                   full;
  logic [2:0]             level;
  logic                   busy;
  axi_aw_pkg::aw_viol_t   viol;
  logic [3:0]             viol_clear;
  logic [15:0]            accept_count;

  apb_aw_regs u_regs (
    .aclk(aclk), .rst_n(rst_n),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .push(push), .push_addr(push_addr), .push_attr(push_attr),
    .full(full), .level(level), .busy(busy),
    .viol(viol), .viol_clear(viol_clear), .accept_count(accept_count)
  );

  aw_cmd_fifo u_fifo (
    .aclk(aclk), .rst_n(rst_n),
    .push(push), .pop(pop), .push_addr(push_addr), .push_attr(push_attr),
    .head_addr(head_addr), .head_attr(head_attr),
    .empty(empty), .full(full), .level(level)
  );

  aw_channel_master u_master (
    .aclk(aclk), .rst_n(rst_n),
    .empty(empty), .head_addr(head_addr), .head_attr(head_attr),
    .pop(pop), .busy(busy),
    .awid(awid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize),
    .awburst(awburst), .awlock(awlock), .awprot(awprot),
    .awvalid(awvalid), .awready(awready)
  );

  // checker only listens on the AW port
  aw_protocol_checker u_checker (
    .aclk(aclk), .rst_n(rst_n),
    .awaddr(awaddr), .awlen(awlen), .awsize(awsize), .awburst(awburst),
    .awvalid(awvalid), .awready(awready),
    .viol_clear(viol_clear), .viol(viol), .accept_count(accept_count)
  );

endmodule

// ==== tb.f ====
+incdir+include
src/axi_aw_pkg.sv
src/apb_aw_regs.sv
src/aw_cmd_fifo.sv
src/aw_channel_master.sv
src/aw_protocol_checker.sv
src/axi_aw_top.sv
bench/tb_axi_aw_top.sv
